// File: include/alu_consts.svh
// ALU constants
// widths shared by the execute stage datapath and branch logic
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// operand and result width
`define XLEN 32

// shift amount field taken from the low bits of the b operand
`define SHAMT_W 5

// 2-bit branch history counter
`define HIST_W 2

`endif

// File: hw/exec_pkg.sv
// execute stage types
// word, PC and history types plus the ALU and branch opcode enums
`include "alu_consts.svh"

package exec_pkg;

   // operand or result word
   typedef logic [`XLEN-1:0] word_t;

   // halfword aligned PC, bit 0 is implied zero
   typedef logic [`XLEN-1:1] pc_t;

   // branch history counter
   typedef logic [`HIST_W-1:0] hist_t;

   // ALU operation from decode
   typedef enum logic [3:0] {
      OP_NONE = 4'd0,
      OP_ADD  = 4'd1,
      OP_SUB  = 4'd2,
      OP_SLT  = 4'd3,
      OP_SLTU = 4'd4,
      OP_AND  = 4'd5,
      OP_OR   = 4'd6,
      OP_XOR  = 4'd7,
      OP_SLL  = 4'd8,
      OP_SRL  = 4'd9,
      OP_SRA  = 4'd10
   } alu_op_t;

   // branch kind from decode
   typedef enum logic [2:0] {
      BR_NONE = 3'd0,
      BR_EQ   = 3'd1,
      BR_NE   = 3'd2,
      BR_LT   = 3'd3,
      BR_GE   = 3'd4,
      BR_LTU  = 3'd5,
      BR_GEU  = 3'd6,
      BR_JAL  = 3'd7
   } br_op_t;

endpackage

// File: hw/alu_shifter.sv
// ALU shifter
// sll, srl and sra from a single right shift of a 63-bit extended operand
// left shifts shift right by the complement amount and mask the low bits
`include "alu_consts.svh"

module alu_shifter (
   input  exec_pkg::word_t    a,
   input  logic [`SHAMT_W-1:0] shamt,
   input  exec_pkg::alu_op_t  op,
   output exec_pkg::word_t    shifted
);
   import exec_pkg::*;

   logic                  is_sll;
   logic                  is_sra;
   logic [`SHAMT_W-1:0]   amount;
   logic [2*`XLEN-2:0]    extended;
   logic [2*`XLEN-2:0]    shifted_long;
   word_t                 mask;

   assign is_sll = (op == OP_SLL);
   assign is_sra = (op == OP_SRA);

   // 32 minus the amount for left shifts, modulo 32
   assign amount = is_sll ? (`SHAMT_W'(0) - shamt) : shamt;

   // low half is always the operand
   assign extended[`XLEN-1:0] = a;

   // upper half holds sign copies for sra or the low bits for sll
   assign extended[2*`XLEN-2:`XLEN] = ({(`XLEN-1){is_sra}} & {(`XLEN-1){a[`XLEN-1]}}) |
                                      ({(`XLEN-1){is_sll}} & a[`XLEN-2:0]);

   assign shifted_long = extended >> amount;

   // clear the bits that wrapped in from the top on a left shift
   assign mask = {`XLEN{1'b1}} << ({`SHAMT_W{is_sll}} & shamt);

   assign shifted = shifted_long[`XLEN-1:0] & mask;

endmodule

// File: hw/alu_datapath.sv
// ALU datapath
// adder, comparator, logic unit and shifter with an AND-OR result select
// the result and PC are registered for the next pipeline stage
`include "alu_consts.svh"

module alu_datapath (
   input  logic              clk,
   input  logic              rst,
   input  logic              enable,
   input  logic              valid_in,
   input  exec_pkg::alu_op_t alu_op,
   input  exec_pkg::br_op_t  br_op,
   input  exec_pkg::word_t   a_in,
   input  exec_pkg::word_t   b_in,
   input  exec_pkg::pc_t     pc_in,
   input  exec_pkg::pc_t     link_addr,
   output exec_pkg::word_t   sum,
   output logic              eq,
   output logic              lt_s,
   output logic              lt_u,
   output exec_pkg::word_t   result_ff,
   output exec_pkg::pc_t     pc_ff
);
   import exec_pkg::*;

   logic  sub_sel;
   logic  sel_add;
   logic  sel_shift;
   logic  sel_pc;
   logic  sel_alu;
   logic  slt_bit;
   word_t b_mux;
   word_t logic_out;
   word_t shift_out;
   word_t result;

   // adder, subtract inverts b and adds the carry in
   assign sub_sel = (alu_op == OP_SUB);
   assign b_mux   = sub_sel ? ~b_in : b_in;
   assign sum     = a_in + b_mux + word_t'(sub_sel);

   // comparator shared by slt and the branch resolver
   assign eq   = (a_in == b_in);
   assign lt_s = ($signed(a_in) < $signed(b_in));
   assign lt_u = (a_in < b_in);

   // logic unit
   assign logic_out = ({`XLEN{alu_op == OP_AND}} & (a_in & b_in)) |
                      ({`XLEN{alu_op == OP_OR}}  & (a_in | b_in)) |
                      ({`XLEN{alu_op == OP_XOR}} & (a_in ^ b_in));

   alu_shifter shifter_i (
      .a       (a_in),
      .shamt   (b_in[`SHAMT_W-1:0]),
      .op      (alu_op),
      .shifted (shift_out)
   );

   assign sel_add   = (alu_op == OP_ADD) || (alu_op == OP_SUB);
   assign sel_shift = (alu_op == OP_SLL) || (alu_op == OP_SRL) || (alu_op == OP_SRA);
   assign slt_bit   = ((alu_op == OP_SLT) & lt_s) | ((alu_op == OP_SLTU) & lt_u);

   // jal overrides the ALU op with the link address
   assign sel_pc  = (br_op == BR_JAL);
   assign sel_alu = ~sel_pc;

   assign result = ({`XLEN{sel_alu & sel_add}}   & sum)                          |
                   ({`XLEN{sel_alu & sel_shift}} & shift_out)                    |
                   ({`XLEN{sel_alu}}             & logic_out)                    |
                   ({`XLEN{sel_alu}}             & {{(`XLEN-1){1'b0}}, slt_bit}) |
                   ({`XLEN{sel_pc}}              & {link_addr, 1'b0});

   // result register, loads only for a valid op in an enabled cycle
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         result_ff <= '0;
      end
      else if (enable && valid_in)
      begin
         result_ff <= result;
      end
   end

   // every PC passes through here, valid or not
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc_ff <= '0;
      end
      else if (enable)
      begin
         pc_ff <= pc_in;
      end
   end

endmodule

// File: hw/branch_resolve.sv
// branch resolver
// decides the branch outcome, checks it against the prediction and
// produces the flush levels, flush path, link address and new history
`include "alu_consts.svh"

module branch_resolve (
   input  logic             valid_in,
   input  exec_pkg::br_op_t br_op,
   input  exec_pkg::pc_t    pc_in,
   input  logic [12:1]      brimm_in,
   input  exec_pkg::word_t  sum,
   input  logic             eq,
   input  logic             lt_s,
   input  logic             lt_u,
   input  logic             predict_t,
   input  logic             predict_nt,
   input  exec_pkg::hist_t  hist_in,
   input  logic             flush_upper_x,
   input  logic             flush_lower_r,
   output exec_pkg::pc_t    link_addr,
   output logic             taken_out,
   output logic             misp_out,
   output exec_pkg::hist_t  hist_out,
   output logic             pred_correct,
   output logic             flush_upper,
   output logic             flush_final,
   output exec_pkg::pc_t    flush_path
);
   import exec_pkg::*;

   logic is_jal;
   logic taken;
   logic mispredict;
   logic redirect;

   // branch target or jal link address, pc plus the sign extended offset
   assign link_addr = pc_in + {{(`XLEN-13){brimm_in[12]}}, brimm_in};

   assign is_jal = (br_op == BR_JAL);

   always_comb
   begin
      case (br_op)
         BR_EQ:   taken = eq;
         BR_NE:   taken = ~eq;
         BR_LT:   taken = lt_s;
         BR_GE:   taken = ~lt_s;
         BR_LTU:  taken = lt_u;
         BR_GEU:  taken = ~lt_u;
         BR_JAL:  taken = 1'b1;
         default: taken = 1'b0;
      endcase
   end

   assign taken_out = taken;

   // wrong direction in either sense
   assign mispredict = (predict_t & ~taken) | (predict_nt & taken);

   // tells next-PC logic the flush path is not needed, never for jal
   assign pred_correct = valid_in & ~is_jal &
                         ((predict_t & taken) | (predict_nt & ~taken));

   assign redirect = (is_jal | mispredict) & valid_in & ~flush_upper_x;

   assign flush_upper = redirect & ~flush_lower_r;
   assign flush_final = redirect | flush_lower_r;

   // adder holds the jal target, otherwise the opposite of the prediction
   assign flush_path = is_jal ? sum[`XLEN-1:1] : link_addr;

   assign misp_out = mispredict & ~flush_upper_x & ~flush_lower_r;

   // 2-bit history update
   // 00 -> 01/10, 01 -> 01/00, 10 -> 00/11, 11 -> 10/11 (not taken/taken)
   assign hist_out[1] = (hist_in[1] & hist_in[0]) | (~hist_in[0] & taken);
   assign hist_out[0] = (~hist_in[1] & ~taken) | (hist_in[1] & taken);

endmodule

// File: hw/alu_top.sv
// integer execute stage top
// connects the ALU datapath to the branch resolver
// the resolver sends the link address back for jal results
module alu_top (
   input  logic              clk,
   input  logic              rst,
   input  logic              enable,
   input  logic              valid_in,
   input  exec_pkg::alu_op_t alu_op,
   input  exec_pkg::br_op_t  br_op,
   input  exec_pkg::word_t   a_in,
   input  exec_pkg::word_t   b_in,
   input  exec_pkg::pc_t     pc_in,
   input  logic [12:1]       brimm_in,
   input  logic              predict_t,
   input  logic              predict_nt,
   input  exec_pkg::hist_t   hist_in,
   input  logic              flush_upper_x,
   input  logic              flush_lower_r,
   output exec_pkg::word_t   result_ff,
   output exec_pkg::pc_t     pc_ff,
   output logic              taken_out,
   output logic              misp_out,
   output exec_pkg::hist_t   hist_out,
   output logic              pred_correct,
   output logic              flush_upper,
   output logic              flush_final,
   output exec_pkg::pc_t     flush_path
);
   import exec_pkg::*;

   word_t sum;
   logic  eq;
   logic  lt_s;
   logic  lt_u;
   pc_t   link_addr;

   alu_datapath datapath_i (
      .clk       (clk),
      .rst       (rst),
      .enable    (enable),
      .valid_in  (valid_in),
      .alu_op    (alu_op),
      .br_op     (br_op),
      .a_in      (a_in),
      .b_in      (b_in),
      .pc_in     (pc_in),
      .link_addr (link_addr),
      .sum       (sum),
      .eq        (eq),
      .lt_s      (lt_s),
      .lt_u      (lt_u),
      .result_ff (result_ff),
      .pc_ff     (pc_ff)
   );

   branch_resolve resolve_i (
      .valid_in      (valid_in),
      .br_op         (br_op),
      .pc_in         (pc_in),
      .brimm_in      (brimm_in),
      .sum           (sum),
      .eq            (eq),
      .lt_s          (lt_s),
      .lt_u          (lt_u),
      .predict_t     (predict_t),
      .predict_nt    (predict_nt),
      .hist_in       (hist_in),
      .flush_upper_x (flush_upper_x),
      .flush_lower_r (flush_lower_r),
      .link_addr     (link_addr),
      .taken_out     (taken_out),
      .misp_out      (misp_out),
      .hist_out      (hist_out),
      .pred_correct  (pred_correct),
      .flush_upper   (flush_upper),
      .flush_final   (flush_final),
      .flush_path    (flush_path)
   );

endmodule

// File: verification/alu_assertions.sv
// execute stage protocol checks
// bound into alu_top, covers the flush levels and the result register hold
module alu_assertions (
   input logic            clk,
   input logic            rst,
   input logic            enable,
   input logic            valid_in,
   input logic            pred_correct,
   input logic            flush_upper,
   input logic            flush_final,
   input exec_pkg::word_t result_ff
);

   // an upper flush is always also a final flush
   upper_implies_final: assert property (@(posedge clk) disable iff (rst)
      flush_upper |-> flush_final)
      else $error("flush_upper is high while flush_final is low");

   // a correct prediction never redirects the front end
   correct_not_flushed: assert property (@(posedge clk) disable iff (rst)
      !(pred_correct && flush_upper))
      else $error("pred_correct and flush_upper are both high");

   // no load unless enable and valid_in were both high on the previous edge
   result_holds: assert property (@(posedge clk) disable iff (rst)
      (!$past(rst) && !$past(enable && valid_in)) |-> (result_ff == $past(result_ff)))
      else $error("result_ff changed while enable or valid_in was low");

endmodule

bind alu_top alu_assertions assertions_i (
   .clk          (clk),
   .rst          (rst),
   .enable       (enable),
   .valid_in     (valid_in),
   .pred_correct (pred_correct),
   .flush_upper  (flush_upper),
   .flush_final  (flush_final),
   .result_ff    (result_ff)
);

// File: verification/alu_tb.sv
// execute stage testbench
// random and directed stimulus on alu_top, checked against a reference model
`include "alu_consts.svh"

module alu_tb;
   import exec_pkg::*;

   localparam int PERIOD       = 8;
   localparam int RESET_CYCLES = 8;
   localparam int SEED         = 97570;
   localparam int N_ALU        = 300;
   localparam int N_BRANCH     = 72;
   localparam int N_JAL        = 40;
   localparam int N_FLUSH      = 100;
   localparam int N_HIST       = 16;
   localparam int N_STALL      = 60;
   localparam int N_VECTORS    = N_ALU + N_BRANCH + N_JAL + N_FLUSH + N_HIST + N_STALL +
                                 3 * RESET_CYCLES;

   typedef struct packed {
      word_t result;
      logic  taken;
      logic  misp;
      hist_t hist;
      logic  pred_correct;
      logic  flush_upper;
      logic  flush_final;
      pc_t   flush_path;
   } expect_t;

   logic        clk;
   logic        rst;
   logic        enable;
   logic        valid_in;
   alu_op_t     alu_op;
   br_op_t      br_op;
   word_t       a_in;
   word_t       b_in;
   pc_t         pc_in;
   logic [12:1] brimm_in;
   logic        predict_t;
   logic        predict_nt;
   hist_t       hist_in;
   logic        flush_upper_x;
   logic        flush_lower_r;
   word_t       result_ff;
   pc_t         pc_ff;
   logic        taken_out;
   logic        misp_out;
   hist_t       hist_out;
   logic        pred_correct;
   logic        flush_upper;
   logic        flush_final;
   pc_t         flush_path;

   bit          check_en;
   int          check_count;
   int          error_count;
   int          test_start_errors;
   word_t       exp_result_ff;
   pc_t         exp_pc_ff;

   alu_top dut_i (.*);

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #(PERIOD / 2) clk = ~clk;
      end
   end

   // expected outputs for one set of inputs
   function automatic expect_t alu_model(
      input alu_op_t op, input br_op_t br, input word_t a, input word_t b,
      input pc_t pc, input logic [12:1] imm, input logic pt, input logic pnt,
      input hist_t hist, input logic valid, input logic fux, input logic flr
   );
      expect_t e;
      word_t   sum;
      pc_t     target;
      int      offset;
      logic    jal;
      logic    misp;
      logic    redirect;

      sum    = (op == OP_SUB) ? a - b : a + b;
      // offset in halfwords as a signed number
      offset = imm[12] ? int'(imm) - 4096 : int'(imm);
      target = pc + pc_t'(offset);
      jal    = (br == BR_JAL);
      case (op)
         OP_ADD:  e.result = a + b;
         OP_SUB:  e.result = a - b;
         OP_SLT:  e.result = ($signed(a) < $signed(b)) ? 1 : 0;
         OP_SLTU: e.result = (a < b) ? 1 : 0;
         OP_AND:  e.result = a & b;
         OP_OR:   e.result = a | b;
         OP_XOR:  e.result = a ^ b;
         OP_SLL:  e.result = a << b[`SHAMT_W-1:0];
         OP_SRL:  e.result = a >> b[`SHAMT_W-1:0];
         OP_SRA:  e.result = word_t'($signed(a) >>> b[`SHAMT_W-1:0]);
         default: e.result = '0;
      endcase
      if (jal)
         e.result = {target, 1'b0};
      case (br)
         BR_EQ:   e.taken = (a == b);
         BR_NE:   e.taken = (a != b);
         BR_LT:   e.taken = ($signed(a) < $signed(b));
         BR_GE:   e.taken = ($signed(a) >= $signed(b));
         BR_LTU:  e.taken = (a < b);
         BR_GEU:  e.taken = (a >= b);
         BR_JAL:  e.taken = 1'b1;
         default: e.taken = 1'b0;
      endcase
      misp           = (pt && !e.taken) || (pnt && e.taken);
      redirect       = valid && (jal || misp) && !fux;
      e.misp         = misp && !fux && !flr;
      e.pred_correct = valid && !jal && ((pt && e.taken) || (pnt && !e.taken));
      e.flush_upper  = redirect && !flr;
      e.flush_final  = redirect || flr;
      e.flush_path   = jal ? sum[`XLEN-1:1] : target;
      case ({hist, e.taken})
         3'b000:  e.hist = 2'b01;
         3'b001:  e.hist = 2'b10;
         3'b010:  e.hist = 2'b01;
         3'b011:  e.hist = 2'b00;
         3'b100:  e.hist = 2'b00;
         3'b101:  e.hist = 2'b11;
         3'b110:  e.hist = 2'b10;
         default: e.hist = 2'b11;
      endcase
      return e;
   endfunction

   task automatic compare_value(input string what, input word_t got, input word_t expected);
      check_count++;
      assert (got === expected)
      else
      begin
         $display("FAIL %0t: %s is %h, expected %h", $time, what, got, expected);
         error_count++;
      end
   endtask

   // edge values show up often
   // shift amounts 0 and 31 come from 0 and all ones
   function automatic word_t pick_operand();
      case ($urandom_range(0, 7))
         0:       return '0;
         1:       return '1;
         2:       return 32'h8000_0000;
         3:       return 32'h7fff_ffff;
         default: return $urandom;
      endcase
   endfunction

   // 0 is no prediction, 1 predicted taken, 2 predicted not taken
   task automatic set_prediction(input int kind);
      predict_t  = (kind == 1);
      predict_nt = (kind == 2);
   endtask

   // plain enabled ALU op with random side inputs
   // each test overrides the fields it needs
   task automatic random_vector();
      enable        = 1'b1;
      valid_in      = 1'b1;
      alu_op        = alu_op_t'(4'($urandom_range(0, 10)));
      br_op         = BR_NONE;
      a_in          = pick_operand();
      b_in          = pick_operand();
      pc_in         = pc_t'($urandom);
      brimm_in      = 12'($urandom);
      hist_in       = hist_t'($urandom);
      set_prediction(0);
      flush_upper_x = 1'b0;
      flush_lower_r = 1'b0;
   endtask

   task automatic finish_test(input string name, input int vectors);
      @(posedge clk);
      #2;
      $display("test %s done, %0d vectors, %0d errors", name, vectors,
               error_count - test_start_errors);
      test_start_errors = error_count;
   endtask

   task automatic check_reset_state();
      compare_value("result_ff after reset", result_ff, '0);
      compare_value("pc_ff after reset", word_t'(pc_ff), '0);
      compare_value("flush_upper after reset", word_t'(flush_upper), '0);
      compare_value("flush_final after reset", word_t'(flush_final), '0);
      compare_value("pred_correct after reset", word_t'(pred_correct), '0);
   endtask

   task automatic run_alu_ops();
      int i;
      for (i = 0; i < N_ALU; i++)
      begin
         @(negedge clk);
         random_vector();
         alu_op = alu_op_t'(4'(i % 11));
      end
      finish_test("alu ops", N_ALU);
   endtask

   task automatic run_branches();
      word_t edge_a [4] = '{32'h8000_0000, 32'h7fff_ffff, 32'h0000_0000, 32'hffff_ffff};
      word_t edge_b [4] = '{32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0000};
      int    kind;
      int    pair;
      int    pred;
      for (kind = 1; kind <= 6; kind++)
         for (pair = 0; pair < 6; pair++)
            for (pred = 1; pred <= 2; pred++)
            begin
               @(negedge clk);
               random_vector();
               br_op = br_op_t'(3'(kind));
               set_prediction(pred);
               if (pair == 0)
                  b_in = a_in;
               else if (pair == 1)
                  b_in = ~a_in;
               else
               begin
                  a_in = edge_a[pair - 2];
                  b_in = edge_b[pair - 2];
               end
            end
      finish_test("conditional branches", N_BRANCH);
   endtask

   task automatic run_jal();
      int i;
      for (i = 0; i < N_JAL; i++)
      begin
         @(negedge clk);
         random_vector();
         alu_op   = OP_ADD;
         br_op    = BR_JAL;
         a_in     = {pc_in, 1'b0};
         b_in     = word_t'($urandom) & ~word_t'(1);
         // link increment of 2 or 4 bytes in halfword units
         brimm_in = ($urandom_range(0, 1) != 0) ? 12'd1 : 12'd2;
         set_prediction($urandom_range(0, 2));
      end
      finish_test("jal", N_JAL);
   endtask

   task automatic run_flush_mix();
      int i;
      for (i = 0; i < N_FLUSH; i++)
      begin
         @(negedge clk);
         random_vector();
         br_op         = br_op_t'(3'($urandom_range(0, 7)));
         valid_in      = ($urandom_range(0, 3) != 0);
         flush_upper_x = 1'($urandom_range(0, 1));
         flush_lower_r = 1'($urandom_range(0, 1));
         set_prediction($urandom_range(0, 2));
      end
      finish_test("flush masking", N_FLUSH);
   endtask

   task automatic run_history();
      int h;
      int t;
      int r;
      for (h = 0; h < 4; h++)
         for (t = 0; t < 2; t++)
            for (r = 0; r < 2; r++)
            begin
               @(negedge clk);
               random_vector();
               br_op   = BR_EQ;
               hist_in = hist_t'(h);
               b_in    = (t != 0) ? a_in : ~a_in;
            end
      finish_test("history", N_HIST);
   endtask

   task automatic run_stall_reset();
      int i;
      for (i = 0; i < N_STALL; i++)
      begin
         @(negedge clk);
         random_vector();
         br_op    = br_op_t'(3'($urandom_range(0, 7)));
         enable   = 1'($urandom_range(0, 1));
         valid_in = 1'($urandom_range(0, 1));
      end
      // reset in the middle of traffic
      // valid_in stays low so the flushes stay quiet
      for (i = 0; i < RESET_CYCLES; i++)
      begin
         @(negedge clk);
         random_vector();
         rst      = 1'b1;
         valid_in = 1'b0;
      end
      @(negedge clk);
      rst    = 1'b0;
      enable = 1'b0;
      #1;
      check_reset_state();
      finish_test("stall and reset", N_STALL + RESET_CYCLES);
   endtask

   // compares the combinational outputs at the edge and the registers just after
   initial
   begin
      expect_t exp_now;
      forever
      begin
         @(posedge clk);
         exp_now = alu_model(alu_op, br_op, a_in, b_in, pc_in, brimm_in, predict_t,
                             predict_nt, hist_in, valid_in, flush_upper_x, flush_lower_r);
         if (check_en)
         begin
            compare_value("taken_out", word_t'(taken_out), word_t'(exp_now.taken));
            compare_value("misp_out", word_t'(misp_out), word_t'(exp_now.misp));
            compare_value("hist_out", word_t'(hist_out), word_t'(exp_now.hist));
            compare_value("pred_correct", word_t'(pred_correct), word_t'(exp_now.pred_correct));
            compare_value("flush_upper", word_t'(flush_upper), word_t'(exp_now.flush_upper));
            compare_value("flush_final", word_t'(flush_final), word_t'(exp_now.flush_final));
            compare_value("flush_path", word_t'(flush_path), word_t'(exp_now.flush_path));
         end
         if (rst)
         begin
            exp_result_ff = '0;
            exp_pc_ff     = '0;
         end
         else
         begin
            if (enable && valid_in)
               exp_result_ff = exp_now.result;
            if (enable)
               exp_pc_ff = pc_in;
         end
         #1;
         if (check_en)
         begin
            compare_value("result_ff", result_ff, exp_result_ff);
            compare_value("pc_ff", word_t'(pc_ff), word_t'(exp_pc_ff));
         end
      end
   end

   initial
   begin
      #(N_VECTORS * PERIOD * 4);
      $display("watchdog timeout, the tests did not finish in time");
      $display("Checks failed");
      $finish;
   end

   initial
   begin
      void'($urandom(SEED));
      check_en          = 1'b0;
      check_count       = 0;
      error_count       = 0;
      test_start_errors = 0;
      rst               = 1'b1;
      random_vector();
      enable            = 1'b0;
      valid_in          = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst      = 1'b0;
      check_en = 1'b1;
      #1;
      check_reset_state();
      run_alu_ops();
      run_branches();
      run_jal();
      run_flush_mix();
      run_history();
      run_stall_reset();
      $display("total %0d checks, %0d errors", check_count, error_count);
      if (error_count == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

// File: build.f
+incdir+include
hw/exec_pkg.sv
hw/alu_shifter.sv
hw/alu_datapath.sv
hw/branch_resolve.sv
hw/alu_top.sv
verification/alu_assertions.sv
verification/alu_tb.sv

// File: Makefile
# Verilator flow for the integer execute stage
TOP = alu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim 2>&1 | tee sim.log
	@if grep -q "Checks failed" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@if ! grep -q "All checks passed" sim.log; then \
		echo "simulation did not complete"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log
